// ==== addTree.f ====
+incdir+dv
rtl/addTreePkg.sv
rtl/prefixCarryNet.sv
rtl/prefixAdder.sv
rtl/bitCompressor.sv
rtl/csaTree.sv
rtl/sumMerge.sv
rtl/multiOperandSum.sv
dv/multiOperandSumTb.sv

// ==== dv/sumVectors.svh ====
`ifndef SUM_VECTORS_SVH
`define SUM_VECTORS_SVH

// each operand set (operand 0 in the low byte) pairs with the exact sum of its eight operands
localparam int numVec = 12;

logic [opCount*opWidth-1:0] vecOps [numVec] = '{
	64'h0000_0000_0000_0000, // all zeros
	64'h0000_0000_0000_00FF, // operand 0 at max
	64'hFF00_0000_0000_0000, // operand 7 at max
	64'hFFFF_FFFF_FFFF_FFFF, // all at max, needs the top sum bit
	64'hAAAA_AAAA_AAAA_AAAA, // alternating bits
	64'h5555_5555_5555_5555,
	64'hAA55_AA55_AA55_AA55, // alternating operands
	64'h0807_0605_0403_0201, // ramp
	64'h8040_2010_0804_0201, // walking one upward
	64'hFF00_FF00_FF00_FF00,
	64'h0102_0408_1020_4080, // walking one downward
	64'h1234_5678_9ABC_DEF0
};

logic [sumWidth-1:0] vecSums [numVec] = '{
	11'd0,
	11'd255,
	11'd255,
	11'd2040,
	11'd1360,
	11'd680,
	11'd1020,
	11'd36,
	11'd255,
	11'd1020,
	11'd255,
	11'd1080
};

`endif

// ==== dv/multiOperandSumTb.sv ====
`timescale 1ns/1ps

module multiOperandSumTb;
	import addTreePkg::*;

	localparam int opWidth  = DEF_WIDTH;
	localparam int opCount  = DEF_DEPTH;
	localparam int sumWidth = opWidth + $clog2(opCount);
	localparam int rstCycles = 8;
	localparam int gapSets   = 40;  // sets with random idle gaps
	localparam int randSets  = 200; // back-to-back random sets

	`include "sumVectors.svh"

	// every phase with its drain, worst-case gaps, plus slack
	localparam int cycleLimit = rstCycles + 10 + numVec + 4 + gapSets * 4 + 4
		+ randSets + 4 + 3 + 3 + 6 + 2 + 4 + 50;

	logic                       clk;
	logic                       rstN;
	logic                       inValid;
	logic [opCount*opWidth-1:0] operands;
	logic                       outValid;
	logic [sumWidth-1:0]        sum;

	logic [sumWidth-1:0] expQ[$];   // expected sums in issue order
	string               nameQ[$];  // test name per pending set
	int                  cycleQ[$]; // cycle the result must show up in
	int                  cycleCnt = 0;
	int                  checkCnt = 0;
	int                  mismatchErrs = 0;
	int                  otherErrs = 0;
	logic [15:0]         lfsrState = 16'd11529;

	multiOperandSum #(
		.width(opWidth),
		.depth(opCount),
		.speed(SPEED_FAST)
	) u_multiOperandSum (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.operands(operands),
		.outValid(outValid),
		.sum     (sum)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit) begin
			$write("timeout at cycle %0d, %0d results pending, ", cycleCnt, expQ.size());
			$display("mismatches: %0d, other errors: %0d", mismatchErrs, otherErrs);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) s = s ^ 16'hB400;
		return s;
	endfunction

	task automatic drawBits(input int n, output logic [opCount*opWidth-1:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState); // one step per bit
			bits = {bits[opCount*opWidth-2:0], lfsrState[0]};
		end
	endtask

	// plain integer sum of the operands
	function automatic logic [sumWidth-1:0] refSum(input logic [opCount*opWidth-1:0] ops);
		int total;
		total = 0;
		for (int k = 0; k < opCount; k++) total += ops[k*opWidth +: opWidth];
		return total[sumWidth-1:0];
	endfunction

	task automatic checkOutputs();
		logic [sumWidth-1:0] expSum;
		string               name;
		int                  expCycle;
		if (outValid) begin
			assert (expQ.size() != 0) else begin
				otherErrs++;
				$display("outValid pulsed at cycle %0d with no result pending", cycleCnt);
			end
			if (expQ.size() != 0) begin
				expSum   = expQ.pop_front();
				name     = nameQ.pop_front();
				expCycle = cycleQ.pop_front();
				checkCnt++;
				assert (sum === expSum) else begin
					mismatchErrs++;
					$display("mismatch in %s: expected %0d, actual %0d", name, expSum, sum);
				end
				assert (cycleCnt == expCycle) else begin
					otherErrs++;
					$display("result of %s arrived in cycle %0d instead of cycle %0d",
						name, cycleCnt, expCycle);
				end
			end
		end
	endtask

	// check outputs then drive the next inputs for one clock
	task automatic runCycle(input logic valid, input logic [opCount*opWidth-1:0] ops,
		input logic [sumWidth-1:0] expSum, input string name);
		@(negedge clk);
		checkOutputs();
		inValid  = valid;
		operands = ops;
		if (valid) begin
			expQ.push_back(expSum);
			nameQ.push_back(name);
			cycleQ.push_back(cycleCnt + 3); // sampled next edge and out two edges later
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) runCycle(1'b0, '0, '0, "idle");
	endtask

	task automatic issueRandom(input string name);
		logic [opCount*opWidth-1:0] ops;
		drawBits(opCount * opWidth, ops);
		runCycle(1'b1, ops, refSum(ops), name);
	endtask

	initial begin
		logic [opCount*opWidth-1:0] gap;
		rstN     = 1'b0;
		inValid  = 1'b0;
		operands = '0;
		repeat (rstCycles) @(negedge clk);
		rstN = 1'b1;

		idleCycles(10); // no strobe, nothing may come out

		for (int i = 0; i < numVec; i++) begin
			runCycle(1'b1, vecOps[i], vecSums[i], $sformatf("directed %0d", i));
		end
		idleCycles(4);

		for (int i = 0; i < gapSets; i++) begin
			drawBits(2, gap);
			issueRandom("random gaps");
			idleCycles(gap[1:0]);
		end
		idleCycles(4);

		for (int i = 0; i < randSets; i++) issueRandom("random");
		idleCycles(4);

		// first of three sets comes out just before reset drops the other two
		repeat (3) issueRandom("reset flush");
		@(negedge clk);
		checkOutputs();
		rstN    = 1'b0;
		inValid = 1'b0;
		expQ.delete();
		nameQ.delete();
		cycleQ.delete();
		repeat (2) begin
			@(negedge clk);
			assert (!outValid) else begin
				otherErrs++;
				$display("outValid high while reset is held");
			end
		end
		rstN = 1'b1;
		idleCycles(6); // flushed sets must not appear
		repeat (2) issueRandom("after reset");
		idleCycles(4);

		assert (expQ.size() == 0) else begin
			otherErrs++;
			$display("%0d issued sets never produced a result", expQ.size());
		end
		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			checkCnt, mismatchErrs, otherErrs);
		if (mismatchErrs + otherErrs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== rtl/multiOperandSum.sv ====
`timescale 1ns/1ps

module multiOperandSum #(
	parameter int                width = addTreePkg::DEF_WIDTH,
	parameter int                depth = addTreePkg::DEF_DEPTH, // even, at least 8
	parameter addTreePkg::speedE speed = addTreePkg::SPEED_FAST
) (
	input  logic                              clk,
	input  logic                              rstN,
	input  logic                              inValid,
	input  logic [depth*width-1:0]            operands, // operand 0 at the low end
	output logic                              outValid,
	output logic [width+$clog2(depth)-1:0]    sum
);

	localparam int sumWidth = width + $clog2(depth); // exact result width
	localparam int half     = depth / 2;             // operands per tree

	logic                        stageValid;
	logic [depth*sumWidth-1:0]   opsQ; // widened operand register
	logic [sumWidth-1:0]         loSum;
	logic [sumWidth-1:0]         loCarry;
	logic [sumWidth-1:0]         hiSum;
	logic [sumWidth-1:0]         hiCarry;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= inValid;
		end
	end

	// zero-extend so all later arithmetic is exact
	always_ff @(posedge clk) begin
		if (inValid) begin
			for (int k = 0; k < depth; k++) begin
				opsQ[k*sumWidth +: sumWidth] <=
					{{(sumWidth - width){1'b0}}, operands[k*width +: width]};
			end
		end
	end

	csaTree #(
		.width(sumWidth),
		.depth(half),
		.speed(speed)
	) loTree (
		.operands (opsQ[half*sumWidth-1:0]),
		.treeSum  (loSum),
		.treeCarry(loCarry)
	);

	csaTree #(
		.width(sumWidth),
		.depth(depth - half),
		.speed(speed)
	) hiTree (
		.operands (opsQ[depth*sumWidth-1:half*sumWidth]),
		.treeSum  (hiSum),
		.treeCarry(hiCarry)
	);

	sumMerge #(
		.width(sumWidth),
		.speed(speed)
	) mergeStage (
		.clk      (clk),
		.rstN     (rstN),
		.halfValid(stageValid),
		.loSum    (loSum),
		.loCarry  (loCarry),
		.hiSum    (hiSum),
		.hiCarry  (hiCarry),
		.outValid (outValid),
		.sum      (sum)
	);

endmodule

// ==== rtl/sumMerge.sv ====
`timescale 1ns/1ps

module sumMerge #(
	parameter int                width = 11,
	parameter addTreePkg::speedE speed = addTreePkg::SPEED_FAST
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             halfValid, // both half trees hold a new set
	input  logic [width-1:0] loSum,
	input  logic [width-1:0] loCarry,
	input  logic [width-1:0] hiSum,
	input  logic [width-1:0] hiCarry,
	output logic             outValid,  // one-cycle pulse
	output logic [width-1:0] sum
);

	logic             midValid;
	logic [4*width-1:0] midVecs; // lo sum at the low end
	logic [width-1:0] mergeSum;
	logic [width-1:0] mergeCarry;
	logic [width-1:0] addOut;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			midValid <= 1'b0;
			outValid <= 1'b0;
		end else begin
			midValid <= halfValid;
			outValid <= midValid;
		end
	end

	always_ff @(posedge clk) begin
		if (halfValid) begin
			midVecs <= {hiCarry, hiSum, loCarry, loSum};
		end
		if (midValid) begin
			sum <= addOut; // held between results
		end
	end

	// 4:2 step
	csaTree #(
		.width(width),
		.depth(4),
		.speed(speed)
	) mergeTree (
		.operands (midVecs),
		.treeSum  (mergeSum),
		.treeCarry(mergeCarry)
	);

	prefixAdder #(
		.width(width),
		.speed(speed)
	) finalAdd (
		.a(mergeSum),
		.b(mergeCarry),
		.s(addOut)
	);

endmodule

// ==== rtl/csaTree.sv ====
`timescale 1ns/1ps

module csaTree #(
	parameter int                width = 8,
	parameter int                depth = 4, // at least 4
	parameter addTreePkg::speedE speed = addTreePkg::SPEED_FAST
) (
	input  logic [depth*width-1:0] operands,  // operand 0 at the low end
	output logic [width-1:0]       treeSum,
	output logic [width-1:0]       treeCarry  // already shifted to its weight
);

	localparam int cw = depth - 3; // slice-to-slice carries per slice

	logic [depth*width-1:0]  byWeight;   // bit b of every operand side by side
	logic [cw*(width+1)-1:0] sliceCarry; // one extra group above the top slice
	logic [width-1:0]        rawCarry;   // slice carries before the shift

	always_comb begin
		for (int b = 0; b < width; b++) begin
			for (int k = 0; k < depth; k++) begin
				byWeight[b*depth+k] = operands[k*width+b];
			end
		end
	end

	assign sliceCarry[cw-1:0] = '0; // nothing enters the lowest slice

	for (genvar b = 0; b < width; b++) begin : slice
		bitCompressor #(
			.depth(depth),
			.speed(speed)
		) cpr (
			.bitsIn  (byWeight[b*depth +: depth]),
			.carryIn (sliceCarry[b*cw +: cw]),
			.sum     (treeSum[b]),
			.carry   (rawCarry[b]),
			.carryOut(sliceCarry[(b+1)*cw +: cw])
		);
	end

	// top slice carries fall out of the word
	// width is sized so the true sum never reaches them
	assign treeCarry = {rawCarry[width-2:0], 1'b0};

endmodule

// ==== rtl/bitCompressor.sv ====
`timescale 1ns/1ps

module bitCompressor #(
	parameter int                depth = 4,
	parameter addTreePkg::speedE speed = addTreePkg::SPEED_FAST
) (
	input  logic [depth-1:0] bitsIn,   // equal-weight input bits
	input  logic [depth-4:0] carryIn,  // from the slice below
	output logic             sum,
	output logic             carry,    // weight of the next slice
	output logic [depth-4:0] carryOut  // to the slice above
);
	import addTreePkg::*;

	logic [depth-3:0] faCarry; // one carry per full adder

	if (speed == SPEED_SLOW) begin : linearCpr
		logic [depth-3:0] chainSum; // running sum down the chain

		// first adder eats three input bits
		assign chainSum[0] = bitsIn[0] ^ bitsIn[1] ^ bitsIn[2];
		assign faCarry[0]  = (bitsIn[0] & bitsIn[1]) | (bitsIn[0] & bitsIn[2])
			| (bitsIn[1] & bitsIn[2]);

		// each later adder takes one new bit and one slice carry
		for (genvar i = 1; i < depth - 2; i++) begin : fa
			assign chainSum[i] = bitsIn[i+2] ^ carryIn[i-1] ^ chainSum[i-1];
			assign faCarry[i]  = (bitsIn[i+2] & carryIn[i-1])
				| (bitsIn[i+2] & chainSum[i-1]) | (carryIn[i-1] & chainSum[i-1]);
		end
		assign sum = chainSum[depth-3];
	end else begin : treeCpr
		// queue of pending bits with inputs first and results appended behind
		logic [3*depth-6:0] fifo;

		assign fifo[depth-1:0] = bitsIn;

		for (genvar i = 0; i < depth - 2; i++) begin : fa
			// pop three from the head
			assign fifo[depth+2*i] = fifo[3*i] ^ fifo[3*i+1] ^ fifo[3*i+2];
			assign faCarry[i]      = (fifo[3*i] & fifo[3*i+1]) | (fifo[3*i] & fifo[3*i+2])
				| (fifo[3*i+1] & fifo[3*i+2]);
			if (i < depth - 3) begin : push
				assign fifo[depth+2*i+1] = carryIn[i]; // push one slice carry
			end
		end
		assign sum = fifo[3*depth-6]; // sum of the last adder
	end

	assign carryOut = faCarry[depth-4:0];
	assign carry    = faCarry[depth-3];

endmodule

// ==== rtl/prefixAdder.sv ====
`timescale 1ns/1ps

module prefixAdder #(
	parameter int                width = 8,
	parameter addTreePkg::speedE speed = addTreePkg::SPEED_FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] s  // a + b modulo 2**width
);
	import addTreePkg::*;

	if (speed == SPEED_SLOW) begin : rippleAdd
		assign s = a + b; // plain carry chain
	end else begin : prefixAdd
		logic [width-1:0] bitGen;  // both bits set
		logic [width-1:0] bitProp; // either bit set
		logic [width-1:0] halfSum;
		logic [width-1:0] grpGen;  // carry out of bits 0..i

		assign bitGen  = a & b;
		assign bitProp = a | b; // or-propagate is enough for carries
		assign halfSum = a ^ b;

		prefixCarryNet #(
			.width(width),
			.speed(speed)
		) carryNet (
			.genIn  (bitGen),
			.propIn (bitProp),
			.genOut (grpGen),
			.propOut()
		);

		// no carry into bit 0
		assign s = halfSum ^ {grpGen[width-2:0], 1'b0};
	end

endmodule

// ==== rtl/prefixCarryNet.sv ====
`timescale 1ns/1ps

module prefixCarryNet #(
	parameter int                width = 8,
	parameter addTreePkg::speedE speed = addTreePkg::SPEED_FAST
) (
	input  logic [width-1:0] genIn,   // bit generate
	input  logic [width-1:0] propIn,  // bit propagate
	output logic [width-1:0] genOut,  // group generate 0..i
	output logic [width-1:0] propOut  // group propagate 0..i
);
	import addTreePkg::*;

	// levels of a full power-of-two tree, at least one
	localparam int lvlCnt = (width > 1) ? $clog2(width) : 1;

	if (speed == SPEED_SLOW) begin : serialNet
		logic [width-1:0] gChain; // running group generate
		logic [width-1:0] pChain; // running group propagate

		assign gChain[0] = genIn[0];
		assign pChain[0] = propIn[0];
		for (genvar i = 1; i < width; i++) begin : node
			assign gChain[i] = genIn[i] | (propIn[i] & gChain[i-1]);
			assign pChain[i] = propIn[i] & pChain[i-1];
		end
		assign genOut  = gChain;
		assign propOut = pChain;
	end else if (speed == SPEED_MEDIUM) begin : brentKungNet
		// row 0 is the input, then lvlCnt up rows and lvlCnt-1 down rows
		logic [2*lvlCnt-1:0][width-1:0] gLvl;
		logic [2*lvlCnt-1:0][width-1:0] pLvl;

		assign gLvl[0] = genIn;
		assign pLvl[0] = propIn;

		// up sweep builds aligned power-of-two groups
		for (genvar l = 1; l <= lvlCnt; l++) begin : upLvl
			for (genvar i = 0; i < width; i++) begin : node
				if ((i + 1) % (2 ** l) == 0) begin : black
					localparam int src = i - 2 ** (l - 1); // top of lower group
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][src]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][src];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		// down sweep fills in the bits between group tops
		for (genvar t = 1; t < lvlCnt; t++) begin : downLvl
			localparam int row  = lvlCnt + t;
			localparam int span = 2 ** (lvlCnt - t - 1); // distance to partner
			for (genvar i = 0; i < width; i++) begin : node
				if ((i % (2 * span) == span - 1) && (i >= 2 * span)) begin : black
					assign gLvl[row][i] = gLvl[row-1][i]
						| (pLvl[row-1][i] & gLvl[row-1][i-span]);
					assign pLvl[row][i] = pLvl[row-1][i] & pLvl[row-1][i-span];
				end else begin : white
					assign gLvl[row][i] = gLvl[row-1][i];
					assign pLvl[row][i] = pLvl[row-1][i];
				end
			end
		end
		assign genOut  = gLvl[2*lvlCnt-1];
		assign propOut = pLvl[2*lvlCnt-1];
	end else begin : sklanskyNet
		logic [lvlCnt:0][width-1:0] gLvl; // row 0 is the input
		logic [lvlCnt:0][width-1:0] pLvl;

		assign gLvl[0] = genIn;
		assign pLvl[0] = propIn;
		for (genvar l = 1; l <= lvlCnt; l++) begin : lvl
			for (genvar i = 0; i < width; i++) begin : node
				// upper half of each 2**l group takes the lower half's top
				if (((i >> (l - 1)) & 1) == 1) begin : black
					localparam int src = ((i >> (l - 1)) << (l - 1)) - 1;
					assign gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][src]);
					assign pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][src];
				end else begin : white
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end
		assign genOut  = gLvl[lvlCnt];
		assign propOut = pLvl[lvlCnt];
	end

endmodule

// ==== rtl/addTreePkg.sv ====
package addTreePkg;

	// architecture choice shared by every block of the adder tree
	typedef enum logic [1:0] {
		SPEED_SLOW   = 2'd0, // linear compressors and ripple add
		SPEED_MEDIUM = 2'd1, // tree compressors and Brent-Kung prefix
		SPEED_FAST   = 2'd2  // tree compressors and Sklansky prefix
	} speedE;

	localparam int DEF_WIDTH = 8; // operand width in bits

	// operand count
	// even and at least 8 so each half tree gets a 4-input compressor
	localparam int DEF_DEPTH = 8;

endpackage
